// ==== common/inputs_defines.svh ====
`ifndef INPUTS_DEFINES_SVH
`define INPUTS_DEFINES_SVH

// Fire buttons per joystick
`define INPUTS_BUTTONS 4

// Paddle centre position after reset
`define INPUTS_PADDLE_INIT 8'h80

// Saturation limits of the emulated paddle
`define INPUTS_PADDLE_MIN 8'h00
`define INPUTS_PADDLE_MAX 8'hff

// A real paddle takes over as soon as its reading moves
`define INPUTS_PADDLE_OVR(cur, last) ((cur) != (last))

`endif

// ==== common/inputs_pkg.sv ====
`default_nettype none

`include "inputs_defines.svh"

package inputs_pkg;

    // Joystick bundle, right is bit 0
    // Board and keyboard side are active high, game side active low
    typedef struct packed {
        logic [`INPUTS_BUTTONS-1:0] buttons;
        logic                       up;
        logic                       down;
        logic                       left;
        logic                       right;
    } joy_t;

    // System buttons, same polarity rules as joy_t
    typedef struct packed {
        logic [1:0] coin;
        logic [1:0] start;
        logic       service;
        logic       test;
        logic       tilt;
        logic [3:0] spare;
    } sys_t;

    // Mouse motion report
    typedef struct packed {
        logic signed [8:0] dx;  // positive moves right
        logic              st;  // one cycle update strobe
    } mouse_t;

    // Pause controller states
    typedef enum logic [1:0] {
        PAUSE_RUN,
        PAUSE_HOLD,
        PAUSE_STEP
    } pause_st_e;

endpackage

`default_nettype wire

// ==== src/joy_merge.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "inputs_defines.svh"

module joy_merge #(
    parameter int BUTTONS = `INPUTS_BUTTONS
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              rot,
    input  logic              rot_ccw,
    input  logic              locked,
    input  logic              key_reset,
    input  inputs_pkg::joy_t  board_joy1,
    input  inputs_pkg::joy_t  board_joy2,
    input  inputs_pkg::joy_t  key_joy1,
    input  inputs_pkg::joy_t  key_joy2,
    input  inputs_pkg::sys_t  board_sys,
    input  inputs_pkg::sys_t  key_sys,
    output inputs_pkg::joy_t  game_joy1,
    output inputs_pkg::joy_t  game_joy2,
    output inputs_pkg::sys_t  game_sys,
    output logic              soft_rst
);
    import inputs_pkg::*;

    localparam int NB = `INPUTS_BUTTONS;

    logic [NB-1:0] btn_used;
    joy_t          next_joy1;
    joy_t          next_joy2;
    logic          key_reset_l;

    // Rotate the stick directions for vertical screens, buttons untouched
    function automatic joy_t rotate_joy(input joy_t j, input logic en, input logic ccw);
        joy_t r;
        r = j;
        if (en && !ccw) begin
            r.up    = j.right;
            r.right = j.down;
            r.down  = j.left;
            r.left  = j.up;
        end else if (en && ccw) begin
            r.up    = j.left;
            r.left  = j.down;
            r.down  = j.right;
            r.right = j.up;
        end
        return r;
    endfunction

    // Buttons the game does not use stay released
    always_comb begin
        for (int i = 0; i < NB; i++) begin
            btn_used[i] = (i < BUTTONS);
        end
    end

    always_comb begin
        next_joy1 = ~rotate_joy(board_joy1 | key_joy1, rot, rot_ccw);
        next_joy2 = ~rotate_joy(board_joy2 | key_joy2, rot, rot_ccw);
        next_joy1.buttons = next_joy1.buttons | ~btn_used;
        next_joy2.buttons = next_joy2.buttons | ~btn_used;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            game_joy1   <= '1;
            game_joy2   <= '1;
            game_sys    <= '1;
            soft_rst    <= 1'b0;
            key_reset_l <= 1'b0;
        end else begin
            // Locked board releases the sticks but not coin/start
            game_joy1   <= locked ? '1 : next_joy1;
            game_joy2   <= locked ? '1 : next_joy2;
            game_sys    <= ~(board_sys | key_sys);
            key_reset_l <= key_reset;
            soft_rst    <= key_reset & ~key_reset_l;
        end
    end

endmodule

`default_nettype wire

// ==== src/pause_ctrl.sv ====
`default_nettype none
`timescale 1ns/1ps

module pause_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic key_pause,
    input  logic osd_pause,
    input  logic adv_frame,    // active low service press
    input  logic lvbl,
    output logic game_pause
);
    import inputs_pkg::*;

    pause_st_e st, st_next;
    logic      key_pause_l;
    logic      adv_frame_l;
    logic      lvbl_l;
    logic      pause_rise;
    logic      adv_fall;
    logic      vb_start;

    assign pause_rise = key_pause & ~key_pause_l;
    assign adv_fall   = adv_frame_l & ~adv_frame;
    assign vb_start   = lvbl_l & ~lvbl;

    always_comb begin
        st_next = st;
        case (st)
            PAUSE_RUN:  if (pause_rise) st_next = PAUSE_HOLD;
            PAUSE_HOLD: begin
                if (pause_rise) begin
                    st_next = PAUSE_RUN;
                end else if (adv_fall) begin
                    st_next = PAUSE_STEP;
                end
            end
            // One frame runs, then freeze again at the next blank
            PAUSE_STEP: if (vb_start) st_next = PAUSE_HOLD;
            default:    st_next = PAUSE_RUN;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            st          <= PAUSE_RUN;
            game_pause  <= 1'b0;
            key_pause_l <= 1'b0;
            adv_frame_l <= 1'b1;
            lvbl_l      <= 1'b1;
        end else begin
            st          <= st_next;
            game_pause  <= (st_next == PAUSE_HOLD) | osd_pause;
            key_pause_l <= key_pause;
            adv_frame_l <= adv_frame;
            lvbl_l      <= lvbl;
        end
    end

endmodule

`default_nettype wire

// ==== src/mouse_paddle.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "inputs_defines.svh"

module mouse_paddle (
    input  logic               clk,
    input  logic               rst_n,
    input  inputs_pkg::mouse_t mouse,
    input  logic [1:0]         sensty,
    input  logic [7:0]         board_paddle,
    output logic [7:0]         game_paddle
);
    logic signed [8:0] dx_s;
    logic signed [8:0] step;
    logic        [9:0] sum;
    logic        [7:0] sat;
    logic        [7:0] board_l;

    // Higher sensty means slower paddle
    assign dx_s = mouse.dx;
    assign step = dx_s >>> sensty;
    assign sum  = {2'b00, game_paddle} + {step[8], step};

    // Bit 9 flags a sum below zero and bit 8 one past full scale
    always_comb begin
        if (sum[9]) begin
            sat = `INPUTS_PADDLE_MIN;
        end else if (sum[8]) begin
            sat = `INPUTS_PADDLE_MAX;
        end else begin
            sat = sum[7:0];
        end
    end

    // Last hardware paddle reading
    always_ff @(posedge clk) begin
        board_l <= board_paddle;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            game_paddle <= `INPUTS_PADDLE_INIT;
        end else if (`INPUTS_PADDLE_OVR(board_paddle, board_l)) begin
            game_paddle <= board_paddle;
        end else if (mouse.st) begin
            game_paddle <= sat;
        end
    end

endmodule

`default_nettype wire

// ==== src/input_hub.sv ====
`default_nettype none
`timescale 1ns/1ps

module input_hub (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               rot,
    input  logic               rot_ccw,
    input  logic               locked,
    input  logic               key_reset,
    input  inputs_pkg::joy_t   board_joy1,
    input  inputs_pkg::joy_t   board_joy2,
    input  inputs_pkg::joy_t   key_joy1,
    input  inputs_pkg::joy_t   key_joy2,
    input  inputs_pkg::sys_t   board_sys,
    input  inputs_pkg::sys_t   key_sys,
    input  logic               key_pause,
    input  logic               osd_pause,
    input  logic               lvbl,
    input  inputs_pkg::mouse_t mouse,
    input  logic [1:0]         sensty,
    input  logic [7:0]         board_paddle,
    output inputs_pkg::joy_t   game_joy1,
    output inputs_pkg::joy_t   game_joy2,
    output inputs_pkg::sys_t   game_sys,
    output logic               soft_rst,
    output logic               game_pause,
    output logic [7:0]         game_paddle
);

    joy_merge u_joy (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .rot        ( rot        ),
        .rot_ccw    ( rot_ccw    ),
        .locked     ( locked     ),
        .key_reset  ( key_reset  ),
        .board_joy1 ( board_joy1 ),
        .board_joy2 ( board_joy2 ),
        .key_joy1   ( key_joy1   ),
        .key_joy2   ( key_joy2   ),
        .board_sys  ( board_sys  ),
        .key_sys    ( key_sys    ),
        .game_joy1  ( game_joy1  ),
        .game_joy2  ( game_joy2  ),
        .game_sys   ( game_sys   ),
        .soft_rst   ( soft_rst   )
    );

    // Service doubles as frame advance while paused
    pause_ctrl u_pause (
        .clk        ( clk              ),
        .rst_n      ( rst_n            ),
        .key_pause  ( key_pause        ),
        .osd_pause  ( osd_pause        ),
        .adv_frame  ( game_sys.service ),
        .lvbl       ( lvbl             ),
        .game_pause ( game_pause       )
    );

    mouse_paddle u_paddle (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .mouse        ( mouse        ),
        .sensty       ( sensty       ),
        .board_paddle ( board_paddle ),
        .game_paddle  ( game_paddle  )
    );

endmodule

`default_nettype wire

// ==== sim/tb_clk_gen.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int HALF_NS    = 2,
    parameter int RST_CYCLES = 2
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #HALF_NS clk = ~clk;
    end

    // Reset leaves 1 ns after an edge, same as the other inputs
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== sim/tb_input_hub.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "inputs_defines.svh"

module tb_input_hub;
    import inputs_pkg::*;

    localparam int NUM_TASKS  = 5;
    localparam int CYCLE_NS   = 4;
    localparam int TIMEOUT_NS = (NUM_TASKS * 200 + 100) * CYCLE_NS;

    logic       clk;
    logic       rst_n;
    logic       rot;
    logic       rot_ccw;
    logic       locked;
    logic       key_reset;
    joy_t       board_joy1;
    joy_t       board_joy2;
    joy_t       key_joy1;
    joy_t       key_joy2;
    sys_t       board_sys;
    sys_t       key_sys;
    logic       key_pause;
    logic       osd_pause;
    logic       lvbl;
    mouse_t     mouse;
    logic [1:0] sensty;
    logic [7:0] board_paddle;
    joy_t       game_joy1;
    joy_t       game_joy2;
    sys_t       game_sys;
    logic       soft_rst;
    logic       game_pause;
    logic [7:0] game_paddle;

    int seed = 51021;
    int errors = 0;
    int checks = 0;
    logic [7:0] paddle_model;

    tb_clk_gen u_clk (
        .clk   ( clk   ),
        .rst_n ( rst_n )
    );

    input_hub UUT (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .rot          ( rot          ),
        .rot_ccw      ( rot_ccw      ),
        .locked       ( locked       ),
        .key_reset    ( key_reset    ),
        .board_joy1   ( board_joy1   ),
        .board_joy2   ( board_joy2   ),
        .key_joy1     ( key_joy1     ),
        .key_joy2     ( key_joy2     ),
        .board_sys    ( board_sys    ),
        .key_sys      ( key_sys      ),
        .key_pause    ( key_pause    ),
        .osd_pause    ( osd_pause    ),
        .lvbl         ( lvbl         ),
        .mouse        ( mouse        ),
        .sensty       ( sensty       ),
        .board_paddle ( board_paddle ),
        .game_joy1    ( game_joy1    ),
        .game_joy2    ( game_joy2    ),
        .game_sys     ( game_sys     ),
        .soft_rst     ( soft_rst     ),
        .game_pause   ( game_pause   ),
        .game_paddle  ( game_paddle  )
    );

    // Outputs are read and inputs driven 1 ns after each rising edge
    task automatic next_cycle;
        @(posedge clk);
        #1;
    endtask

    task automatic check_joy(input string name, input joy_t exp, input joy_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error: %s expected 0x%h, got 0x%h", name, exp, act);
        end
    endtask

    task automatic check_sys(input string name, input sys_t exp, input sys_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error: %s expected 0x%h, got 0x%h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error: %s expected 0x%h, got 0x%h", name, exp, act);
        end
    endtask

    task automatic check_paddle(input string name, input logic [7:0] exp, input logic [7:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error: %s expected 0x%h, got 0x%h", name, exp, act);
        end
    endtask

    // Expected game side stick after OR, rotation, inversion and lock
    function automatic joy_t expect_joy(input joy_t b, input joy_t k, input logic rot_en,
                                        input logic ccw, input logic lock);
        joy_t m;
        joy_t g;
        m = b | k;
        g = m;
        if (rot_en && ccw) begin
            g.up    = m.left;
            g.left  = m.down;
            g.down  = m.right;
            g.right = m.up;
        end else if (rot_en) begin
            g.up    = m.right;
            g.right = m.down;
            g.down  = m.left;
            g.left  = m.up;
        end
        if (lock) begin
            g = '0;
        end
        return ~g;
    endfunction

    // Shifted mouse step added to the paddle and clamped to 0..255
    function automatic logic [7:0] expect_paddle(input logic [7:0] cur,
                                                 input logic signed [8:0] dx,
                                                 input logic [1:0] sens);
        int step;
        int pos;
        step = dx;
        step = step >>> sens;
        pos  = cur;
        pos  = pos + step;
        if (pos < 0) begin
            pos = 0;
        end else if (pos > 255) begin
            pos = 255;
        end
        return pos[7:0];
    endfunction

    task automatic test_reset_values;
        check_joy("game_joy1", '1, game_joy1);
        check_joy("game_joy2", '1, game_joy2);
        check_sys("game_sys", '1, game_sys);
        check_bit("soft_rst", 1'b0, soft_rst);
        check_bit("game_pause", 1'b0, game_pause);
        check_paddle("game_paddle", `INPUTS_PADDLE_INIT, game_paddle);
    endtask

    // Modes 0 to 3 are unrotated, clockwise, counter-clockwise and locked
    task automatic test_merge;
        logic [31:0] r;
        joy_t        e1;
        joy_t        e2;
        sys_t        es;
        for (int m = 0; m < 4; m++) begin
            for (int i = 0; i < 8; i++) begin
                r          = $random(seed);
                rot        = (m == 1) || (m == 2) || (m == 3 && r[0]);
                rot_ccw    = (m == 2);
                locked     = (m == 3);
                board_joy1 = r[7:0];
                key_joy1   = r[15:8];
                board_joy2 = r[23:16];
                key_joy2   = r[31:24];
                r          = $random(seed);
                board_sys  = r[10:0];
                key_sys    = r[21:11];
                e1 = expect_joy(board_joy1, key_joy1, rot, rot_ccw, locked);
                e2 = expect_joy(board_joy2, key_joy2, rot, rot_ccw, locked);
                es = ~(board_sys | key_sys);
                next_cycle;
                check_joy("game_joy1", e1, game_joy1);
                check_joy("game_joy2", e2, game_joy2);
                check_sys("game_sys", es, game_sys);
            end
        end
        rot        = 1'b0;
        rot_ccw    = 1'b0;
        locked     = 1'b0;
        board_joy1 = '0;
        board_joy2 = '0;
        key_joy1   = '0;
        key_joy2   = '0;
        board_sys  = '0;
        key_sys    = '0;
        next_cycle;
    endtask

    task automatic test_soft_reset;
        check_bit("soft_rst", 1'b0, soft_rst);
        key_reset = 1'b1;
        for (int i = 0; i < 5; i++) begin
            next_cycle;
            check_bit("soft_rst", (i == 0), soft_rst);
        end
        key_reset = 1'b0;
        repeat (3) begin
            next_cycle;
            check_bit("soft_rst", 1'b0, soft_rst);
        end
    endtask

    task automatic press_pause_key(input logic exp_after);
        key_pause = 1'b1;
        next_cycle;
        check_bit("game_pause", exp_after, game_pause);
        next_cycle;
        check_bit("game_pause", exp_after, game_pause);
        key_pause = 1'b0;
        next_cycle;
        check_bit("game_pause", exp_after, game_pause);
    endtask

    task automatic test_pause;
        press_pause_key(1'b1);
        press_pause_key(1'b0);
        // On-screen menu forces the pause
        osd_pause = 1'b1;
        next_cycle;
        check_bit("game_pause", 1'b1, game_pause);
        osd_pause = 1'b0;
        next_cycle;
        check_bit("game_pause", 1'b0, game_pause);
        // Frame advance from hold
        press_pause_key(1'b1);
        board_sys.service = 1'b1;
        next_cycle;
        check_bit("game_pause", 1'b1, game_pause);
        next_cycle;
        check_bit("game_pause", 1'b0, game_pause);
        board_sys.service = 1'b0;
        repeat (4) begin
            next_cycle;
            check_bit("game_pause", 1'b0, game_pause);
        end
        lvbl = 1'b0;
        next_cycle;
        check_bit("game_pause", 1'b1, game_pause);
        lvbl = 1'b1;
        next_cycle;
        check_bit("game_pause", 1'b1, game_pause);
        press_pause_key(1'b0);
    endtask

    task automatic strobe_mouse(input logic signed [8:0] dx);
        mouse.dx     = dx;
        mouse.st     = 1'b1;
        paddle_model = expect_paddle(paddle_model, dx, sensty);
        next_cycle;
        check_paddle("game_paddle", paddle_model, game_paddle);
    endtask

    task automatic test_paddle;
        logic [31:0] r;
        paddle_model = `INPUTS_PADDLE_INIT;
        for (int s = 0; s < 4; s++) begin
            sensty = s[1:0];
            for (int i = 0; i < 10; i++) begin
                r = $random(seed);
                strobe_mouse(r[8:0]);
            end
        end
        // Drive into both saturation ends
        sensty = 2'd0;
        repeat (3) strobe_mouse(9'sd255);
        repeat (3) strobe_mouse(-9'sd256);
        // No strobe means no movement
        mouse.st = 1'b0;
        mouse.dx = 9'sd100;
        next_cycle;
        check_paddle("game_paddle", paddle_model, game_paddle);
        // Hardware paddle wins over a strobe in the same cycle
        board_paddle = 8'h3c;
        mouse.dx     = 9'sd20;
        mouse.st     = 1'b1;
        paddle_model = 8'h3c;
        next_cycle;
        check_paddle("game_paddle", paddle_model, game_paddle);
        strobe_mouse(9'sd5);
        mouse.st = 1'b0;
        next_cycle;
        check_paddle("game_paddle", paddle_model, game_paddle);
        // A moving hardware paddle takes over without any strobe
        board_paddle = 8'hc8;
        paddle_model = 8'hc8;
        next_cycle;
        check_paddle("game_paddle", paddle_model, game_paddle);
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("Simulation timed out after %0d ns, tests did not finish", TIMEOUT_NS);
        $display("Test failures found");
        $finish;
    end

    initial begin
        rot          = 1'b0;
        rot_ccw      = 1'b0;
        locked       = 1'b0;
        key_reset    = 1'b0;
        board_joy1   = '0;
        board_joy2   = '0;
        key_joy1     = '0;
        key_joy2     = '0;
        board_sys    = '0;
        key_sys      = '0;
        key_pause    = 1'b0;
        osd_pause    = 1'b0;
        lvbl         = 1'b1;
        mouse        = '0;
        sensty       = 2'd0;
        board_paddle = 8'h00;
        // Outputs seen here still come from the last reset cycle
        wait (rst_n === 1'b1);
        test_reset_values;
        test_merge;
        test_soft_reset;
        test_pause;
        test_paddle;
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+common
common/inputs_pkg.sv
src/joy_merge.sv
src/pause_ctrl.sv
src/mouse_paddle.sv
src/input_hub.sv
sim/tb_clk_gen.sv
sim/tb_input_hub.sv
